// ==== include/dcache_cfg.svh ====
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// address and data width, cpu and memory side alike
`define DC_XLEN 32

// cache geometry, 16 x 64 B = 1 KB
`define DC_LINES      16
`define DC_LINE_BYTES 64
`define DC_BEATS      16  // 32-bit beats per line

// top address nibble of the uncached region
`define DC_UNCACHED_TOP 4'hA

// derived field widths
`define DC_IDX_W  ($clog2(`DC_LINES))
`define DC_OFF_W  ($clog2(`DC_LINE_BYTES))
`define DC_TAG_W  (`DC_XLEN - `DC_IDX_W - `DC_OFF_W)
`define DC_BEAT_W ($clog2(`DC_BEATS))  // burst counter / word select
`define DC_BYTES  (`DC_XLEN / 8)       // byte lanes per word

// burst encodings on the memory port
`define DC_BURST_SIZE 4'd2  // 4 bytes per beat

`endif

// ==== hw/dcache_pkg.sv ====
`include "dcache_cfg.svh"

package dcache_pkg;

  // one cpu address, seen flat or split into its cache fields
  typedef union packed {
    logic [`DC_XLEN-1:0] word;
    struct packed {
      logic [`DC_TAG_W-1:0] tag;
      logic [`DC_IDX_W-1:0] idx;
      logic [`DC_OFF_W-1:0] off;  // byte offset in line
    } f;
  } dc_addr_u;

  // controller states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITEBACK,  // dirty victim out, 16 beats
    ST_REFILL,     // line in, 16 beats
    ST_UC_READ,    // single beat, bypasses the arrays
    ST_UC_WRITE
  } dc_state_e;

endpackage

// ==== hw/dcache_tag.sv ====
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module dcache_tag (
  input  logic                  clk,
  input  logic                  rst,
  input  dcache_pkg::dc_addr_u  addr_i,        // request address
  input  logic                  tag_wen_i,     // write tag, set valid
  input  logic                  dirty_i,       // dirty value to store
  output logic                  hit_o,
  output logic                  dirty_o,       // indexed line is valid and dirty
  output logic [`DC_TAG_W-1:0]  victim_tag_o   // stored tag of indexed line
);

  logic [`DC_TAG_W-1:0] tag_mem [`DC_LINES];
  logic [`DC_LINES-1:0] valid_q;
  logic [`DC_LINES-1:0] dirty_q;
  logic [`DC_IDX_W-1:0] idx;

  assign idx = addr_i.f.idx;

  // combinational lookup
  assign victim_tag_o = tag_mem[idx];
  assign hit_o        = valid_q[idx] && (tag_mem[idx] == addr_i.f.tag);
  assign dirty_o      = valid_q[idx] && dirty_q[idx];  // clean if never filled

  // valid and dirty bits, cleared on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (tag_wen_i) begin
      valid_q[idx] <= 1'b1;
      dirty_q[idx] <= dirty_i;  // 0 after refill, 1 on write hit
    end
  end

  // tag array itself
  always_ff @(posedge clk) begin
    if (tag_wen_i) begin
      tag_mem[idx] <= addr_i.f.tag;
    end
  end

endmodule

// ==== hw/dcache_data.sv ====
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module dcache_data (
  input  logic                   clk,
  input  dcache_pkg::dc_addr_u   addr_i,         // request address
  input  logic [`DC_BEAT_W-1:0]  beat_i,         // burst position
  input  logic                   refill_wen_i,
  input  logic [`DC_XLEN-1:0]    refill_word_i,  // beat from memory
  input  logic                   hit_wen_i,
  input  logic [`DC_XLEN-1:0]    hit_word_i,     // cpu store data
  input  logic [`DC_BYTES-1:0]   hit_mask_i,     // cpu byte enables
  output logic [`DC_XLEN-1:0]    rdata_o,        // word at request offset
  output logic [`DC_XLEN-1:0]    wb_word_o       // word at burst position
);

  localparam int unsigned BSEL_W = $clog2(`DC_BYTES);

  // line store, one word per beat
  logic [`DC_XLEN-1:0]   line_mem [`DC_LINES][`DC_BEATS];
  logic [`DC_IDX_W-1:0]  idx;
  logic [`DC_BEAT_W-1:0] word_sel;
  logic [`DC_XLEN-1:0]   merged;

  assign idx      = addr_i.f.idx;
  assign word_sel = addr_i.f.off[`DC_OFF_W-1:BSEL_W];  // drop byte bits

  assign rdata_o   = line_mem[idx][word_sel];
  assign wb_word_o = line_mem[idx][beat_i];

  // byte merge of store data over the current word
  always_comb begin
    merged = rdata_o;
    for (int b = 0; b < `DC_BYTES; b++) begin
      if (hit_mask_i[b]) begin
        merged[8*b +: 8] = hit_word_i[8*b +: 8];
      end
    end
  end

  // refill and hit write never overlap, refill first anyway
  always_ff @(posedge clk) begin
    if (refill_wen_i) begin
      line_mem[idx][beat_i] <= refill_word_i;
    end else if (hit_wen_i) begin
      line_mem[idx][word_sel] <= merged;
    end
  end

endmodule

// ==== hw/dcache_ctrl.sv ====
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module dcache_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  // cpu side
  input  logic [`DC_XLEN-1:0]   mem_addr_i,
  input  logic [`DC_XLEN-1:0]   mem_wdata_i,
  input  logic [`DC_BYTES-1:0]  mem_mask_i,
  input  logic [3:0]            mem_size_i,
  input  logic                  mem_addr_valid_i,   // level, held until ready
  input  logic                  mem_write_valid_i,  // 1 store, 0 load
  output logic [`DC_XLEN-1:0]   mem_rdata_o,
  output logic                  mem_data_ready_o,   // one-cycle done pulse
  // memory read side
  output logic [`DC_XLEN-1:0]   arb_araddr,
  output logic                  arb_arvalid,
  output logic [3:0]            arb_rsize,
  output logic [7:0]            arb_rlen,
  input  logic                  arb_rvalid,
  input  logic [`DC_XLEN-1:0]   arb_rdata,
  // memory write side
  output logic [`DC_XLEN-1:0]   arb_awaddr,
  output logic                  arb_awvalid,
  output logic [`DC_BYTES-1:0]  arb_wmask,
  output logic [3:0]            arb_wsize,
  output logic [7:0]            arb_wlen,
  input  logic                  arb_wready,
  output logic [`DC_XLEN-1:0]   arb_wdata,
  // tag and data stores
  input  logic                  hit_i,
  input  logic                  dirty_i,           // indexed line dirty
  input  logic [`DC_TAG_W-1:0]  victim_tag_i,
  input  logic [`DC_XLEN-1:0]   rdata_i,
  input  logic [`DC_XLEN-1:0]   wb_word_i,
  output logic                  tag_wen_o,
  output logic                  dirty_o,           // dirty value to store
  output logic [`DC_BEAT_W-1:0] beat_o,
  output logic                  refill_wen_o,
  output logic                  hit_wen_o
);

  import dcache_pkg::*;

  localparam logic [7:0] BURST_LEN = 8'(`DC_BEATS - 1);  // arb len is beats-1

  dc_state_e state_q;
  dc_addr_u  req;

  logic                  ready_q;
  logic [`DC_BEAT_W-1:0] beat_q;
  logic                  ar_valid_q;
  logic                  aw_valid_q;
  logic [`DC_XLEN-1:0]   araddr_q;
  logic [`DC_XLEN-1:0]   awaddr_q;
  logic [3:0]            rsize_q;
  logic [3:0]            wsize_q;
  logic [7:0]            rlen_q;
  logic [7:0]            wlen_q;
  logic [`DC_BYTES-1:0]  wmask_q;
  logic [`DC_XLEN-1:0]   wdata_q;     // uncached store word
  logic [`DC_XLEN-1:0]   uc_rdata_q;  // uncached load word

  logic                  uncached;
  logic                  accept;
  logic                  cached_req;
  logic                  r_hs;
  logic                  w_hs;
  logic                  last_beat;
  logic [`DC_XLEN-1:0]   line_addr;
  logic [`DC_XLEN-1:0]   victim_addr;

  assign req      = mem_addr_i;
  assign uncached = (req.word[`DC_XLEN-1 -: 4] == `DC_UNCACHED_TOP);

  // new request only in idle and not in the ready cycle
  assign accept     = (state_q == ST_IDLE) && mem_addr_valid_i && !ready_q;
  assign cached_req = accept && !uncached;

  assign r_hs      = ar_valid_q && arb_rvalid;  // accepted read beat
  assign w_hs      = aw_valid_q && arb_wready;  // accepted write beat
  assign last_beat = (beat_q == `DC_BEAT_W'(`DC_BEATS - 1));

  // line-aligned burst addresses
  assign line_addr   = {req.f.tag, req.f.idx, {`DC_OFF_W{1'b0}}};
  assign victim_addr = {victim_tag_i, req.f.idx, {`DC_OFF_W{1'b0}}};

  // store write enables, all combinational
  assign hit_wen_o    = cached_req && hit_i && mem_write_valid_i;  // same edge as ready
  assign refill_wen_o = (state_q == ST_REFILL) && r_hs;
  assign tag_wen_o    = hit_wen_o || (refill_wen_o && last_beat);
  assign dirty_o      = hit_wen_o;  // refill leaves the line clean
  assign beat_o       = beat_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= ST_IDLE;
      ready_q    <= 1'b0;
      beat_q     <= '0;
      ar_valid_q <= 1'b0;
      aw_valid_q <= 1'b0;
    end else begin
      ready_q <= 1'b0;  // pulse by default
      unique case (state_q)
        ST_IDLE: begin
          if (accept && uncached) begin
            if (mem_write_valid_i) begin
              state_q    <= ST_UC_WRITE;
              aw_valid_q <= 1'b1;
              awaddr_q   <= req.word;
              wmask_q    <= mem_mask_i;  // cpu byte lanes go out as is
              wsize_q    <= mem_size_i;
              wlen_q     <= 8'd0;
              wdata_q    <= mem_wdata_i;
            end else begin
              state_q    <= ST_UC_READ;
              ar_valid_q <= 1'b1;
              araddr_q   <= req.word;
              rsize_q    <= mem_size_i;
              rlen_q     <= 8'd0;
            end
          end else if (cached_req && hit_i) begin
            ready_q <= 1'b1;  // read or write hit, done next cycle
          end else if (cached_req && dirty_i) begin
            state_q    <= ST_WRITEBACK;  // victim out before refill
            aw_valid_q <= 1'b1;
            awaddr_q   <= victim_addr;
            wmask_q    <= '1;
            wsize_q    <= `DC_BURST_SIZE;
            wlen_q     <= BURST_LEN;
            beat_q     <= '0;
          end else if (cached_req) begin
            state_q    <= ST_REFILL;
            ar_valid_q <= 1'b1;
            araddr_q   <= line_addr;
            rsize_q    <= `DC_BURST_SIZE;
            rlen_q     <= BURST_LEN;
            beat_q     <= '0;
          end
        end
        ST_WRITEBACK: begin
          if (w_hs) begin
            if (last_beat) begin
              // straight into the refill
              state_q    <= ST_REFILL;
              aw_valid_q <= 1'b0;
              ar_valid_q <= 1'b1;
              araddr_q   <= line_addr;
              rsize_q    <= `DC_BURST_SIZE;
              rlen_q     <= BURST_LEN;
              beat_q     <= '0;
            end else begin
              beat_q <= beat_q + 1'b1;  // next word onto arb_wdata
            end
          end
        end
        ST_REFILL: begin
          if (r_hs) begin
            if (last_beat) begin
              state_q    <= ST_IDLE;  // request replays as a hit
              ar_valid_q <= 1'b0;
              beat_q     <= '0;
            end else begin
              beat_q <= beat_q + 1'b1;
            end
          end
        end
        ST_UC_READ: begin
          if (r_hs) begin
            state_q    <= ST_IDLE;
            ar_valid_q <= 1'b0;
            uc_rdata_q <= arb_rdata;
            ready_q    <= 1'b1;
          end
        end
        ST_UC_WRITE: begin
          if (w_hs) begin
            state_q    <= ST_IDLE;
            aw_valid_q <= 1'b0;
            ready_q    <= 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // cpu return, address is still held while ready is high
  assign mem_data_ready_o = ready_q;
  assign mem_rdata_o      = uncached ? uc_rdata_q : rdata_i;

  // memory request outputs
  assign arb_araddr  = araddr_q;
  assign arb_arvalid = ar_valid_q;
  assign arb_rsize   = rsize_q;
  assign arb_rlen    = rlen_q;
  assign arb_awaddr  = awaddr_q;
  assign arb_awvalid = aw_valid_q;
  assign arb_wmask   = wmask_q;
  assign arb_wsize   = wsize_q;
  assign arb_wlen    = wlen_q;
  assign arb_wdata   = (state_q == ST_WRITEBACK) ? wb_word_i : wdata_q;  // line word per beat

endmodule

// ==== hw/dcache_top.sv ====
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module dcache_top (
  input  logic                  clk,
  input  logic                  rst,
  // cpu load/store port
  input  logic [`DC_XLEN-1:0]   mem_addr_i,
  input  logic [`DC_XLEN-1:0]   mem_wdata_i,
  input  logic [`DC_BYTES-1:0]  mem_mask_i,
  input  logic [3:0]            mem_size_i,
  input  logic                  mem_addr_valid_i,
  input  logic                  mem_write_valid_i,
  output logic [`DC_XLEN-1:0]   mem_rdata_o,
  output logic                  mem_data_ready_o,
  // burst memory, read
  output logic [`DC_XLEN-1:0]   arb_araddr,
  output logic                  arb_arvalid,
  output logic [3:0]            arb_rsize,
  output logic [7:0]            arb_rlen,
  input  logic                  arb_rvalid,
  input  logic [`DC_XLEN-1:0]   arb_rdata,
  // burst memory, write
  output logic [`DC_XLEN-1:0]   arb_awaddr,
  output logic                  arb_awvalid,
  output logic [`DC_BYTES-1:0]  arb_wmask,
  output logic [3:0]            arb_wsize,
  output logic [7:0]            arb_wlen,
  input  logic                  arb_wready,
  output logic [`DC_XLEN-1:0]   arb_wdata
);

  logic                  hit;
  logic                  line_dirty;   // stored dirty of indexed line
  logic [`DC_TAG_W-1:0]  victim_tag;
  logic [`DC_XLEN-1:0]   rdata;
  logic [`DC_XLEN-1:0]   wb_word;
  logic                  tag_wen;
  logic                  dirty_set;    // dirty value written with the tag
  logic [`DC_BEAT_W-1:0] beat;
  logic                  refill_wen;
  logic                  hit_wen;

  dcache_ctrl i_ctrl (
    .clk               (clk),
    .rst               (rst),
    .mem_addr_i        (mem_addr_i),
    .mem_wdata_i       (mem_wdata_i),
    .mem_mask_i        (mem_mask_i),
    .mem_size_i        (mem_size_i),
    .mem_addr_valid_i  (mem_addr_valid_i),
    .mem_write_valid_i (mem_write_valid_i),
    .mem_rdata_o       (mem_rdata_o),
    .mem_data_ready_o  (mem_data_ready_o),
    .arb_araddr        (arb_araddr),
    .arb_arvalid       (arb_arvalid),
    .arb_rsize         (arb_rsize),
    .arb_rlen          (arb_rlen),
    .arb_rvalid        (arb_rvalid),
    .arb_rdata         (arb_rdata),
    .arb_awaddr        (arb_awaddr),
    .arb_awvalid       (arb_awvalid),
    .arb_wmask         (arb_wmask),
    .arb_wsize         (arb_wsize),
    .arb_wlen          (arb_wlen),
    .arb_wready        (arb_wready),
    .arb_wdata         (arb_wdata),
    .hit_i             (hit),
    .dirty_i           (line_dirty),
    .victim_tag_i      (victim_tag),
    .rdata_i           (rdata),
    .wb_word_i         (wb_word),
    .tag_wen_o         (tag_wen),
    .dirty_o           (dirty_set),
    .beat_o            (beat),
    .refill_wen_o      (refill_wen),
    .hit_wen_o         (hit_wen)
  );

  // both stores index straight off the cpu address
  dcache_tag i_tag (
    .clk          (clk),
    .rst          (rst),
    .addr_i       (mem_addr_i),
    .tag_wen_i    (tag_wen),
    .dirty_i      (dirty_set),
    .hit_o        (hit),
    .dirty_o      (line_dirty),
    .victim_tag_o (victim_tag)
  );

  dcache_data i_data (
    .clk           (clk),
    .addr_i        (mem_addr_i),
    .beat_i        (beat),
    .refill_wen_i  (refill_wen),
    .refill_word_i (arb_rdata),   // refill beats land directly
    .hit_wen_i     (hit_wen),
    .hit_word_i    (mem_wdata_i),
    .hit_mask_i    (mem_mask_i),
    .rdata_o       (rdata),
    .wb_word_o     (wb_word)
  );

endmodule

// ==== verif/dcache_assert.sv ====
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module dcache_assert (
  input logic               clk,
  input logic               rst,
  input logic               ready_i,    // cpu done pulse
  input logic               arvalid_i,
  input logic               awvalid_i,
  input logic [`DC_XLEN-1:0] araddr_i
);

  int fail_cnt = 0;  // failed assertions so far

  // one burst direction at a time, writeback hands over to refill
  a_one_channel: assert property (@(posedge clk) disable iff (rst)
    !(arvalid_i && awvalid_i))
    else begin
      $error("read and write burst requests active in the same cycle");
      fail_cnt++;
    end

  // done is a single-cycle pulse
  a_ready_pulse: assert property (@(posedge clk) disable iff (rst)
    ready_i |=> !ready_i)
    else begin
      $error("mem_data_ready_o stayed high for more than one cycle");
      fail_cnt++;
    end

  // read address held until the last beat
  a_araddr_stable: assert property (@(posedge clk) disable iff (rst)
    arvalid_i |=> (!arvalid_i || $stable(araddr_i)))
    else begin
      $error("arb_araddr changed while arb_arvalid was high");
      fail_cnt++;
    end

endmodule

// ==== verif/dcache_tb.sv ====
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module dcache_tb;

  localparam int MEM_WORDS  = 4096;  // 16 KB backing store, addr[13:2]
  // ~35 accesses, worst case writeback plus refill with gaps is ~50 cycles
  localparam int MAX_CYCLES = 4000;

  typedef struct packed {
    logic        write;
    logic [31:0] addr;
    logic [7:0]  beats;  // beats seen on the port
    logic [7:0]  len;
    logic [3:0]  size;
    logic [3:0]  mask;   // 0 for reads
  } burst_t;

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] mem_addr_i;
  logic [31:0] mem_wdata_i;
  logic [3:0]  mem_mask_i;
  logic [3:0]  mem_size_i;
  logic        mem_addr_valid_i;
  logic        mem_write_valid_i;
  logic [31:0] mem_rdata_o;
  logic        mem_data_ready_o;
  logic [31:0] arb_araddr;
  logic        arb_arvalid;
  logic [3:0]  arb_rsize;
  logic [7:0]  arb_rlen;
  logic        arb_rvalid;
  logic [31:0] arb_rdata;
  logic [31:0] arb_awaddr;
  logic        arb_awvalid;
  logic [3:0]  arb_wmask;
  logic [3:0]  arb_wsize;
  logic [7:0]  arb_wlen;
  logic        arb_wready;
  logic [31:0] arb_wdata;

  integer      seed = 32'h98032f83;
  int          val_errs = 0;
  int          oth_errs = 0;
  int unsigned cycles = 0;
  logic [31:0] mem [MEM_WORDS];     // memory model
  logic [31:0] sh_mem [MEM_WORDS];  // shadow, architectural view
  logic        ref_valid [16];      // cache tag model
  logic        ref_dirty [16];
  logic [21:0] ref_tag [16];
  logic [7:0]  rd_cnt = '0;
  logic [7:0]  wr_cnt = '0;
  burst_t      rd_burst;            // open read burst
  burst_t      wr_burst;            // open write burst
  burst_t      act_bursts[$];
  burst_t      exp_bursts[$];
  logic [63:0] act_wbeats[$];       // {addr, data}
  logic [63:0] exp_wbeats[$];
  logic [31:0] got_q[$];
  logic [31:0] exp_q[$];
  int          lat_q[$];            // hit latencies in cycles

  dcache_top i_dut (.*);

  bind dcache_top dcache_assert i_assert (
    .clk       (clk),
    .rst       (rst),
    .ready_i   (mem_data_ready_o),
    .arvalid_i (arb_arvalid),
    .awvalid_i (arb_awvalid),
    .araddr_i  (arb_araddr)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] fill_word(input logic [11:0] i);
    return {4'hD, i, 4'h6, i ^ 12'hA5C};  // whole word index in both halves
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wd,
                                              input logic [3:0] mask);
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) old[8*b +: 8] = wd[8*b +: 8];
    end
    return old;
  endfunction

  // expected read word, bursts and write beats of one cpu access
  function automatic logic [31:0] ref_access(input logic [31:0] addr, input logic write,
                                             input logic [31:0] wdata, input logic [3:0] mask,
                                             input logic [3:0] size, output logic hit);
    logic [3:0]  line;
    logic [21:0] tag;
    logic [11:0] w;
    logic [31:0] vaddr;
    line = addr[9:6];
    tag  = addr[31:10];
    w    = addr[13:2];
    hit  = 1'b0;
    if (addr[31:28] == `DC_UNCACHED_TOP) begin  // single beat, cache untouched
      exp_bursts.push_back(burst_t'{write, addr, 8'd1, 8'd0, size, write ? mask : 4'h0});
      if (write) begin
        exp_wbeats.push_back({addr, wdata});  // full word out, mask on the side
        sh_mem[w] = merge_bytes(sh_mem[w], wdata, mask);
      end
      return sh_mem[w];
    end
    if (ref_valid[line] && ref_tag[line] == tag) begin
      hit = 1'b1;
    end else begin
      if (ref_valid[line] && ref_dirty[line]) begin
        vaddr = {ref_tag[line], line, 6'd0};  // victim line out first
        exp_bursts.push_back(burst_t'{1'b1, vaddr, 8'd16, 8'd15, 4'd2, 4'hF});
        for (int i = 0; i < 16; i++) begin
          exp_wbeats.push_back({vaddr + 32'(i * 4), sh_mem[vaddr[13:2] + 12'(i)]});
        end
      end
      exp_bursts.push_back(burst_t'{1'b0, {addr[31:6], 6'd0}, 8'd16, 8'd15, 4'd2, 4'h0});
      ref_valid[line] = 1'b1;
      ref_tag[line]   = tag;
      ref_dirty[line] = 1'b0;
    end
    if (write) begin
      sh_mem[w] = merge_bytes(sh_mem[w], wdata, mask);
      ref_dirty[line] = 1'b1;
    end
    return sh_mem[w];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
      val_errs++;
    end
  endtask

  task automatic compare_burst(input burst_t got, input burst_t exp);
    assert (got.write == exp.write) else begin
      $display("burst on the wrong channel at %0t, expected one to %h", $time, exp.addr);
      oth_errs++;
    end
    if (got.write == exp.write) begin
      check_value(exp.write ? "arb_awaddr" : "arb_araddr", got.addr, exp.addr);
      check_value("burst beats", 32'(got.beats), 32'(exp.beats));
      check_value(exp.write ? "arb_wlen" : "arb_rlen", 32'(got.len), 32'(exp.len));
      check_value(exp.write ? "arb_wsize" : "arb_rsize", 32'(got.size), 32'(exp.size));
      check_value("arb_wmask", 32'(got.mask), 32'(exp.mask));
    end
  endtask

  // drive one request, hold it until the done pulse
  task automatic cpu_access(input logic [31:0] addr, input logic write,
                            input logic [31:0] wdata, input logic [3:0] mask,
                            input logic [3:0] size);
    logic [31:0] exp_word;
    logic        exp_hit;
    int          lat;
    exp_word          = ref_access(addr, write, wdata, mask, size, exp_hit);
    mem_addr_i        = addr;
    mem_wdata_i       = wdata;
    mem_mask_i        = mask;
    mem_size_i        = size;
    mem_write_valid_i = write;
    mem_addr_valid_i  = 1'b1;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!mem_data_ready_o);
    if (!write) begin
      got_q.push_back(mem_rdata_o);  // address still held here
      exp_q.push_back(exp_word);
    end
    if (exp_hit) lat_q.push_back(lat);
    mem_addr_valid_i = 1'b0;
    @(negedge clk);  // let the ready cycle pass
  endtask

  // memory model, decides beats on the falling edge
  always @(negedge clk) begin
    logic [31:0] a;
    arb_rvalid = 1'b0;
    arb_wready = 1'b0;
    // a burst is over once its valid has dropped
    if (!arb_arvalid && rd_cnt != 0) begin
      rd_burst.beats = rd_cnt;
      act_bursts.push_back(rd_burst);
      rd_cnt = '0;
    end
    if (!arb_awvalid && wr_cnt != 0) begin
      wr_burst.beats = wr_cnt;
      act_bursts.push_back(wr_burst);
      wr_cnt = '0;
    end
    if (!rst && arb_arvalid && (($random(seed) & 3) != 0)) begin  // ~1 in 4 gaps
      if (rd_cnt == 0) begin
        rd_burst = burst_t'{1'b0, arb_araddr, 8'd0, arb_rlen, arb_rsize, 4'h0};
      end
      a          = arb_araddr + {22'd0, rd_cnt, 2'b00};
      arb_rvalid = 1'b1;
      arb_rdata  = mem[a[13:2]];
      rd_cnt++;
    end
    if (!rst && arb_awvalid && (($random(seed) & 3) != 0)) begin
      if (wr_cnt == 0) begin
        wr_burst = burst_t'{1'b1, arb_awaddr, 8'd0, arb_wlen, arb_wsize, arb_wmask};
      end
      a          = arb_awaddr + {22'd0, wr_cnt, 2'b00};
      arb_wready = 1'b1;
      mem[a[13:2]] = merge_bytes(mem[a[13:2]], arb_wdata, arb_wmask);
      act_wbeats.push_back({a, arb_wdata});
      wr_cnt++;
    end
  end

  // compare, away from the driving edge
  always @(posedge clk) begin
    while (got_q.size() > 0) check_value("mem_rdata_o", got_q.pop_front(), exp_q.pop_front());
    while (lat_q.size() > 0) begin
      check_value("mem_data_ready_o latency", 32'(lat_q.pop_front()), 32'd1);
    end
    while (act_bursts.size() > 0 && exp_bursts.size() > 0) begin
      compare_burst(act_bursts.pop_front(), exp_bursts.pop_front());
    end
    while (act_wbeats.size() > 0 && exp_wbeats.size() > 0) begin
      logic [63:0] g;
      logic [63:0] e;
      g = act_wbeats.pop_front();
      e = exp_wbeats.pop_front();
      check_value("arb_awaddr beat", g[63:32], e[63:32]);
      check_value("arb_wdata", g[31:0], e[31:0]);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("timeout, the cache did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] d;
    mem_addr_i        = '0;
    mem_wdata_i       = '0;
    mem_mask_i        = '0;
    mem_size_i        = '0;
    mem_addr_valid_i  = 1'b0;
    mem_write_valid_i = 1'b0;
    arb_rvalid        = 1'b0;
    arb_rdata         = '0;
    arb_wready        = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]    = fill_word(12'(i));
      sh_mem[i] = fill_word(12'(i));
    end
    for (int l = 0; l < 16; l++) begin
      ref_valid[l] = 1'b0;
      ref_dirty[l] = 1'b0;
      ref_tag[l]   = '0;
    end
    rst = 1'b1;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    cpu_access(32'h0000_0104, 1'b0, '0, 4'h0, 4'd2);             // cold miss, refill
    cpu_access(32'h0000_0108, 1'b0, '0, 4'h0, 4'd2);             // hit, 1 cycle
    cpu_access(32'h0000_0108, 1'b1, 32'hCAFE_F00D, 4'b0101, 4'd2);  // masked write hit
    cpu_access(32'h0000_0108, 1'b0, '0, 4'h0, 4'd2);             // merged word back
    cpu_access(32'h0000_0504, 1'b0, '0, 4'h0, 4'd2);             // same index, dirty victim
    cpu_access(32'h0000_0108, 1'b0, '0, 4'h0, 4'd2);             // written data from memory
    cpu_access(32'hA000_3D04, 1'b0, '0, 4'h0, 4'd1);             // uncached read, index 4
    cpu_access(32'hA000_3D08, 1'b1, 32'h1234_5678, 4'b0011, 4'd1);
    cpu_access(32'hA000_3D08, 1'b0, '0, 4'h0, 4'd2);
    cpu_access(32'h0000_0108, 1'b0, '0, 4'h0, 4'd2);             // tags untouched, still a hit
    // random traffic over 8 KB, many conflicts
    for (int n = 0; n < 24; n++) begin
      r = $random(seed);
      d = $random(seed);
      cpu_access({19'd0, r[12:2], 2'b00}, r[20], d, r[27:24], 4'd2);
    end
    repeat (3) @(negedge clk);  // let the compare process drain
    assert (act_bursts.size() == 0 && exp_bursts.size() == 0) else begin
      $display("burst count mismatch, %0d unexpected and %0d missing bursts",
               act_bursts.size(), exp_bursts.size());
      oth_errs++;
    end
    assert (act_wbeats.size() == 0 && exp_wbeats.size() == 0) else begin
      $display("write beat count mismatch, %0d unexpected and %0d missing beats",
               act_wbeats.size(), exp_wbeats.size());
      oth_errs++;
    end
    $display("errors: %0d value, %0d other, %0d assertion", val_errs, oth_errs,
             i_dut.i_assert.fail_cnt);
    if (val_errs + oth_errs + i_dut.i_assert.fail_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+include
hw/dcache_pkg.sv
hw/dcache_tag.sv
hw/dcache_data.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
verif/dcache_assert.sv
verif/dcache_tb.sv

// ==== Makefile ====
TOP = dcache_tb

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module dcache_top

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
